//--- src/stcPkg.sv
package stcPkg;

    // sample format is Q2.16
    localparam int SAMPLE_WIDTH = 18;
    localparam int FRAC_BITS = 16;
    localparam logic signed [SAMPLE_WIDTH-1:0] ONE = 1 << FRAC_BITS;

    // residual headroom for two products plus the received sample
    localparam int RES_WIDTH = SAMPLE_WIDTH + 3;
    localparam int METRIC_WIDTH = 24;

    localparam int CODEWORDS_PER_FRAME = 8;
    localparam int SPARE_CODEWORDS = 1;
    localparam int FRAME_PAIRS = CODEWORDS_PER_FRAME + SPARE_CODEWORDS;
    localparam int FRAME_COUNT_WIDTH = $clog2(FRAME_PAIRS + 1);

    localparam int BUFFER_DEPTH = 64;
    localparam int PTR_WIDTH = $clog2(BUFFER_DEPTH);
    localparam int COUNT_WIDTH = PTR_WIDTH + 1;

    localparam int PAIR_SPACING = 20;
    localparam int SPACE_WIDTH = $clog2(PAIR_SPACING);

    localparam int HYPOTHESES = 16;
    localparam int HYP_WIDTH = $clog2(HYPOTHESES);

    typedef struct packed {
        logic signed [SAMPLE_WIDTH-1:0] re;
        logic signed [SAMPLE_WIDTH-1:0] im;
    } complexSample;

    // wider complex value for products and residuals
    typedef struct packed {
        logic signed [RES_WIDTH-1:0] re;
        logic signed [RES_WIDTH-1:0] im;
    } complexWide;

    typedef struct packed {
        complexSample slot0;    // first time slot of the codeword
        complexSample slot1;
    } samplePair;

    typedef struct packed {
        complexSample h0;
        complexSample h1;
    } channelEst;

    // a set bit means that component is -ONE
    typedef struct packed {
        logic s0Re;
        logic s0Im;
        logic s1Re;
        logic s1Im;
    } decision;

    typedef enum logic [1:0] {
        ALIGN_IDLE,
        ALIGN_RELEASE,
        ALIGN_WAIT
    } alignState;

    typedef enum logic [1:0] {
        DET_IDLE,
        DET_SEARCH,
        DET_DONE
    } detectState;

endpackage

//--- src/frameAligner.sv
`timescale 1ns/1ps

module frameAligner (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 frameStart,
    input  logic                 inputValid,
    input  stcPkg::complexSample din,
    output logic                 full,
    output logic                 pairValid,
    output stcPkg::samplePair    pair
);
    import stcPkg::*;

    complexSample buffer [BUFFER_DEPTH];

    logic [PTR_WIDTH-1:0]         wrPtr;
    logic [PTR_WIDTH-1:0]         rdPtr;
    logic [COUNT_WIDTH-1:0]       count;
    alignState                    state;
    logic [SPACE_WIDTH-1:0]       spaceCnt;
    logic [FRAME_COUNT_WIDTH-1:0] pairsSent;
    logic                         push;
    logic                         pop;

    assign full = (count == COUNT_WIDTH'(BUFFER_DEPTH));
    assign push = inputValid && !full;    // samples are dropped while full
    assign pop = (state == ALIGN_RELEASE) && (count >= COUNT_WIDTH'(2));

    // storage and pair read
    always_ff @(posedge clk) begin
        if (push) begin
            buffer[wrPtr] <= din;
        end
        if (pop) begin
            pair.slot0 <= buffer[rdPtr];
            pair.slot1 <= buffer[rdPtr + PTR_WIDTH'(1)];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + PTR_WIDTH'(1);
            end
            if (pop) begin
                rdPtr <= rdPtr + PTR_WIDTH'(2);
            end
            if (push && !pop) begin
                count <= count + COUNT_WIDTH'(1);
            end else if (!push && pop) begin
                count <= count - COUNT_WIDTH'(2);
            end else if (push && pop) begin
                count <= count - COUNT_WIDTH'(1);
            end
        end
    end

    // release pacing
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ALIGN_IDLE;
            pairValid <= 1'b0;
            spaceCnt <= '0;
            pairsSent <= '0;
        end else begin
            pairValid <= pop;
            case (state)
                ALIGN_IDLE: begin
                    if (frameStart) begin
                        state <= ALIGN_RELEASE;
                        pairsSent <= '0;
                    end
                end
                ALIGN_RELEASE: begin
                    if (pop) begin
                        state <= ALIGN_WAIT;
                        spaceCnt <= '0;
                        pairsSent <= pairsSent + FRAME_COUNT_WIDTH'(1);
                    end
                end
                ALIGN_WAIT: begin
                    // next pairValid lands exactly PAIR_SPACING cycles on
                    if (spaceCnt == SPACE_WIDTH'(PAIR_SPACING - 2)) begin
                        if (pairsSent == FRAME_COUNT_WIDTH'(FRAME_PAIRS)) begin
                            state <= ALIGN_IDLE;
                        end else begin
                            state <= ALIGN_RELEASE;
                        end
                    end else begin
                        spaceCnt <= spaceCnt + SPACE_WIDTH'(1);
                    end
                end
                default: state <= ALIGN_IDLE;
            endcase
        end
    end

    countBounded: assert property (@(posedge clk) disable iff (reset)
        count <= COUNT_WIDTH'(BUFFER_DEPTH));

    noPairWhenIdle: assert property (@(posedge clk) disable iff (reset)
        pairValid |-> state != ALIGN_IDLE);

endmodule

//--- src/stcDetector.sv
`timescale 1ns/1ps

module stcDetector (
    input  logic              clk,
    input  logic              reset,
    input  logic              estimatesDone,
    input  stcPkg::channelEst estIn,
    input  logic              pairValid,
    input  stcPkg::samplePair pair,
    output logic              decisionValid,
    output stcPkg::decision   dec
);
    import stcPkg::*;

    logic                    estDoneDly;
    channelEst               est;
    samplePair               pairReg;
    detectState              state;
    logic [HYP_WIDTH-1:0]    hypIdx;
    logic [HYP_WIDTH-1:0]    bestIdx;
    logic [METRIC_WIDTH-1:0] metric;
    logic [METRIC_WIDTH-1:0] bestMetric;
    logic                    better;
    decision                 hyp;
    complexWide              h0S0;
    complexWide              h1S1;
    complexWide              h1S0Conj;
    complexWide              h0S1Conj;
    complexWide              res0;
    complexWide              res1;

    // QPSK point from two sign bits
    function automatic complexSample symbol(input logic reNeg, input logic imNeg);
        complexSample s;
        s.re = reNeg ? -ONE : ONE;
        s.im = imNeg ? -ONE : ONE;
        return s;
    endfunction

    function automatic complexWide cmulShift(input complexSample a, input complexSample b);
        logic signed [2*SAMPLE_WIDTH-1:0] rr;
        logic signed [2*SAMPLE_WIDTH-1:0] ii;
        logic signed [2*SAMPLE_WIDTH-1:0] ri;
        logic signed [2*SAMPLE_WIDTH-1:0] ir;
        complexWide p;
        rr = a.re * b.re;
        ii = a.im * b.im;
        ri = a.re * b.im;
        ir = a.im * b.re;
        p.re = RES_WIDTH'(rr >>> FRAC_BITS) - RES_WIDTH'(ii >>> FRAC_BITS);
        p.im = RES_WIDTH'(ri >>> FRAC_BITS) + RES_WIDTH'(ir >>> FRAC_BITS);
        return p;
    endfunction

    function automatic logic [METRIC_WIDTH-1:0] absVal(input logic signed [RES_WIDTH-1:0] x);
        logic signed [RES_WIDTH-1:0] m;
        m = x[RES_WIDTH-1] ? -x : x;
        return METRIC_WIDTH'(unsigned'(m));
    endfunction

    // Alamouti residuals for the current hypothesis
    always_comb begin
        hyp = decision'(hypIdx);
        h0S0 = cmulShift(est.h0, symbol(hyp.s0Re, hyp.s0Im));
        h1S1 = cmulShift(est.h1, symbol(hyp.s1Re, hyp.s1Im));
        h1S0Conj = cmulShift(est.h1, symbol(hyp.s0Re, !hyp.s0Im));
        h0S1Conj = cmulShift(est.h0, symbol(hyp.s1Re, !hyp.s1Im));
        res0.re = RES_WIDTH'(pairReg.slot0.re) - (h0S0.re + h1S1.re);
        res0.im = RES_WIDTH'(pairReg.slot0.im) - (h0S0.im + h1S1.im);
        res1.re = RES_WIDTH'(pairReg.slot1.re) - (h1S0Conj.re - h0S1Conj.re);
        res1.im = RES_WIDTH'(pairReg.slot1.im) - (h1S0Conj.im - h0S1Conj.im);
        metric = absVal(res0.re) + absVal(res0.im) + absVal(res1.re) + absVal(res1.im);
        better = (hypIdx == '0) || (metric < bestMetric);    // ties keep the lower index
    end

    // delayed estimate capture
    always_ff @(posedge clk) begin
        if (reset) begin
            estDoneDly <= 1'b0;
        end else begin
            estDoneDly <= estimatesDone;
        end
        if (estDoneDly) begin
            est <= estIn;
        end
    end

    always_ff @(posedge clk) begin
        if (pairValid) begin
            pairReg <= pair;
        end
        if (state == DET_SEARCH && better) begin
            bestMetric <= metric;
            bestIdx <= hypIdx;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DET_IDLE;
            hypIdx <= '0;
        end else begin
            case (state)
                DET_IDLE: begin
                    if (pairValid) begin
                        state <= DET_SEARCH;
                        hypIdx <= '0;
                    end
                end
                DET_SEARCH: begin
                    hypIdx <= hypIdx + HYP_WIDTH'(1);
                    if (hypIdx == HYP_WIDTH'(HYPOTHESES - 1)) begin
                        state <= DET_DONE;
                    end
                end
                DET_DONE: state <= DET_IDLE;
                default: state <= DET_IDLE;
            endcase
        end
    end

    assign decisionValid = (state == DET_DONE);
    assign dec = decision'(bestIdx);    // final once search ends

    pairOnlyWhenIdle: assert property (@(posedge clk) disable iff (reset)
        pairValid |-> state == DET_IDLE);

    decisionLatency: assert property (@(posedge clk) disable iff (reset)
        pairValid |-> ##(HYPOTHESES + 1) decisionValid);

endmodule

//--- src/frameOutput.sv
`timescale 1ns/1ps

module frameOutput (
    input  logic            clk,
    input  logic            reset,
    input  logic            frameStart,
    input  logic            decisionValid,
    input  stcPkg::decision dec,
    output logic            outputEn,
    output stcPkg::decision outputBits,
    output logic            lastSampleReset
);
    import stcPkg::*;

    logic [FRAME_COUNT_WIDTH-1:0] decCount;
    logic                         counted;
    logic                         frameDone;

    // first SPARE_CODEWORDS decisions of a frame are dropped
    assign counted = decisionValid
        && (decCount >= FRAME_COUNT_WIDTH'(SPARE_CODEWORDS))
        && (decCount < FRAME_COUNT_WIDTH'(FRAME_PAIRS));
    assign frameDone = (decCount == FRAME_COUNT_WIDTH'(FRAME_PAIRS));

    always_ff @(posedge clk) begin
        if (reset || frameStart || frameDone) begin
            decCount <= '0;
        end else if (decisionValid) begin
            decCount <= decCount + FRAME_COUNT_WIDTH'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outputEn <= 1'b0;
            outputBits <= '0;
            lastSampleReset <= 1'b0;
        end else begin
            outputEn <= counted;
            lastSampleReset <= frameDone;    // one cycle behind the last outputEn
            if (counted) begin
                outputBits <= dec;
            end
        end
    end

    enAndLastExclusive: assert property (@(posedge clk) disable iff (reset)
        !(outputEn && lastSampleReset));

endmodule

//--- src/stcDemod.sv
`timescale 1ns/1ps

module stcDemod (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 frameStart,
    input  logic                 inputValid,
    input  stcPkg::complexSample din,
    input  logic                 estimatesDone,
    input  stcPkg::channelEst    estIn,
    output logic                 full,
    output logic                 outputEn,
    output stcPkg::decision      outputBits,
    output logic                 lastSampleReset
);
    import stcPkg::*;

    logic      pairValid;
    samplePair pair;
    logic      decisionValid;
    decision   dec;

    // paced sample pairs
    frameAligner aligner (
        .clk        (clk),
        .reset      (reset),
        .frameStart (frameStart),
        .inputValid (inputValid),
        .din        (din),
        .full       (full),
        .pairValid  (pairValid),
        .pair       (pair)
    );

    stcDetector detector (
        .clk           (clk),
        .reset         (reset),
        .estimatesDone (estimatesDone),
        .estIn         (estIn),
        .pairValid     (pairValid),
        .pair          (pair),
        .decisionValid (decisionValid),
        .dec           (dec)
    );

    frameOutput framer (
        .clk             (clk),
        .reset           (reset),
        .frameStart      (frameStart),
        .decisionValid   (decisionValid),
        .dec             (dec),
        .outputEn        (outputEn),
        .outputBits      (outputBits),
        .lastSampleReset (lastSampleReset)
    );

endmodule

//--- tb/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;    // 4 ns period

endmodule

//--- tb/stcDemodTb.sv
`timescale 1ns/1ps

module stcDemodTb;
    import stcPkg::*;

    logic         clk;
    logic         reset;
    logic         frameStart;
    logic         inputValid;
    complexSample din;
    logic         estimatesDone;
    channelEst    estIn;
    logic         full;
    logic         outputEn;
    decision      outputBits;
    logic         lastSampleReset;

    decision outQueue[$];    // decisions seen on outputEn
    int      lastCount;
    int      frameCount;
    int      cycleCount;
    int      cycleLimit;
    int      fd;
    int      lineCount;
    int      fields;
    int      n;
    int      v[8];
    byte     cmd;
    string   line;

    clockGen clkSource (
        .clk (clk)
    );

    stcDemod stcDemod_inst (
        .clk             (clk),
        .reset           (reset),
        .frameStart      (frameStart),
        .inputValid      (inputValid),
        .din             (din),
        .estimatesDone   (estimatesDone),
        .estIn           (estIn),
        .full            (full),
        .outputEn        (outputEn),
        .outputBits      (outputBits),
        .lastSampleReset (lastSampleReset)
    );

    function automatic complexSample makeSample(input int re, input int im);
        complexSample s;
        s.re = SAMPLE_WIDTH'(re);
        s.im = SAMPLE_WIDTH'(im);
        return s;
    endfunction

    task automatic checkValue(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("Error at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic stopOnProblem(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    // one falling edge with all strobes low
    task automatic idleCycle();
        @(negedge clk);
        inputValid = 1'b0;
        frameStart = 1'b0;
        estimatesDone = 1'b0;
    endtask

    task automatic writeSample(input complexSample s);
        @(negedge clk);
        frameStart = 1'b0;
        estimatesDone = 1'b0;
        inputValid = 1'b1;
        din = s;
    endtask

    // sampled away from the rising edge
    always @(negedge clk) begin
        if (!reset) begin
            if (outputEn) begin
                outQueue.push_back(outputBits);
            end
            if (lastSampleReset) begin
                lastCount = lastCount + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit != 0 && cycleCount > cycleLimit) begin
            $display("Timeout: the run went past %0d cycles", cycleLimit);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        reset = 1'b1;
        frameStart = 1'b0;
        inputValid = 1'b0;
        din = '0;
        estimatesDone = 1'b0;
        estIn = '0;
        lastCount = 0;
        frameCount = 0;
        cycleCount = 0;
        cycleLimit = 0;

        // size the timeout from the stimulus length
        lineCount = 0;
        fd = $fopen("tb/stcDemod_stimulus.txt", "r");
        if (fd == 0) begin
            stopOnProblem("Could not open the stimulus file tb/stcDemod_stimulus.txt");
        end
        while ($fgets(line, fd) != 0) begin
            lineCount = lineCount + 1;
        end
        $fclose(fd);
        cycleLimit = lineCount * (PAIR_SPACING + HYPOTHESES) * 2;

        repeat (3) @(negedge clk);
        reset = 1'b0;
        checkValue(int'(outputEn), 0, "outputEn after reset");
        checkValue(int'(lastSampleReset), 0, "lastSampleReset after reset");
        checkValue(int'(full), 0, "full after reset");
        checkValue(int'(outputBits), 0, "outputBits after reset");

        fd = $fopen("tb/stcDemod_stimulus.txt", "r");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            cmd = line.getc(0);
            case (cmd)
                "E": begin
                    fields = $sscanf(line, "%c %h %h %h %h", cmd, v[0], v[1], v[2], v[3]);
                    if (fields != 5) stopOnProblem({"Malformed estimate line: ", line});
                    @(negedge clk);
                    inputValid = 1'b0;
                    frameStart = 1'b0;
                    estIn.h0 = makeSample(v[0], v[1]);
                    estIn.h1 = makeSample(v[2], v[3]);
                    estimatesDone = 1'b1;
                    idleCycle();    // estIn stays held
                    idleCycle();
                    estIn = '0;    // estimates only valid for two cycles
                end
                "S": begin
                    fields = $sscanf(line, "%c %d %h %h %h %h", cmd, n, v[0], v[1], v[2], v[3]);
                    if (fields != 6) stopOnProblem({"Malformed sample line: ", line});
                    repeat (n) begin
                        writeSample(makeSample(v[0], v[1]));
                        writeSample(makeSample(v[2], v[3]));
                    end
                    idleCycle();
                end
                "F": begin
                    // previous frame must be fully delivered
                    checkValue(outQueue.size(), 0, "extra decisions before frameStart");
                    checkValue(lastCount, frameCount, "lastSampleReset pulses");
                    frameCount = frameCount + 1;
                    @(negedge clk);
                    inputValid = 1'b0;
                    estimatesDone = 1'b0;
                    frameStart = 1'b1;
                    idleCycle();
                end
                "W": begin
                    fields = $sscanf(line, "%c %d", cmd, n);
                    if (fields != 2) stopOnProblem({"Malformed wait line: ", line});
                    repeat (n) idleCycle();
                end
                "X": begin
                    fields = $sscanf(line, "%c %h %h %h %h %h %h %h %h", cmd,
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                    if (fields != 9) stopOnProblem({"Malformed expect line: ", line});
                    while (outQueue.size() < CODEWORDS_PER_FRAME) @(negedge clk);
                    for (int i = 0; i < CODEWORDS_PER_FRAME; i++) begin
                        checkValue(int'(outQueue.pop_front()), v[i], "decision");
                    end
                end
                "O": begin
                    fields = $sscanf(line, "%c %d", cmd, n);
                    if (fields != 2) stopOnProblem({"Malformed full line: ", line});
                    @(negedge clk);
                    checkValue(int'(full), n, "full");
                end
                default: stopOnProblem({"Unknown command in stimulus file: ", line});
            endcase
        end
        $fclose(fd);

        repeat (4) idleCycle();
        checkValue(outQueue.size(), 0, "decisions left after last frame");
        checkValue(lastCount, frameCount, "lastSampleReset pulses at end");
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- tb/stcDemod_stimulus.txt
# E h0re h0im h1re h1im | S repeat slot0re slot0im slot1re slot1im | F | W cycles
# X eight expected decisions | O expected full   (sample values are 18-bit hex, Q2.16)
E 10000 00000 00000 00000
S 1 30000 30000 10000 30000
S 1 10000 10000 30000 10000
S 1 10000 30000 30000 30000
S 1 30000 10000 10000 10000
S 1 30000 30000 10000 30000
S 1 10000 10000 10000 30000
S 1 30000 30000 30000 10000
S 1 10000 30000 10000 10000
S 1 30000 10000 30000 30000
F
X 0 5 a f 3 c 6 9
W 30
S 1 10000 10000 30000 10000
S 1 00000 00000 00000 00000
S 1 0e000 32000 12000 2e000
S 1 2e000 12000 0e000 32000
S 1 32000 2e000 2e000 32000
S 1 2e000 32000 0e000 12000
S 1 12000 0e000 0e000 12000
S 1 32000 0e000 2e000 12000
S 1 0e000 12000 32000 2e000
F
X 0 7 b d e 2 8 1
W 30
E 00000 00000 10000 00000
S 1 00000 00000 00000 00000
S 1 10000 10000 30000 10000
S 1 10000 30000 30000 30000
S 1 30000 10000 10000 10000
S 1 30000 30000 10000 30000
S 1 10000 10000 10000 30000
S 1 30000 30000 30000 10000
S 1 10000 30000 10000 10000
S 1 30000 10000 30000 30000
F
X c 9 6 3 0 f 5 a
W 30
E 10000 00000 00000 00000
S 1 00000 00000 00000 00000
S 1 10000 10000 30000 10000
S 1 10000 30000 30000 30000
S 1 30000 10000 10000 10000
S 1 30000 30000 10000 30000
S 1 10000 10000 10000 30000
S 1 30000 30000 30000 10000
S 1 10000 30000 10000 10000
S 1 30000 10000 30000 30000
F
X 0 5 a f 3 c 6 9
W 30
O 0
S 1 10000 10000 30000 10000
S 1 00000 00000 00000 00000
S 1 0e000 32000 12000 2e000
S 1 2e000 12000 0e000 32000
S 1 32000 2e000 2e000 32000
S 1 2e000 32000 0e000 12000
S 1 12000 0e000 0e000 12000
S 1 32000 0e000 2e000 12000
S 1 0e000 12000 32000 2e000
S 25 30000 30000 10000 30000
O 1
F
X 0 7 b d e 2 8 1
W 30
O 0

//--- verilog.f
src/stcPkg.sv
src/frameAligner.sv
src/stcDetector.sv
src/frameOutput.sv
src/stcDemod.sv
tb/clockGen.sv
tb/stcDemodTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= stcDemodTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# exit status of the simulation is the result
sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
